/* logic/cordic_apb_regs.sv */
// APB slave, always zero wait states, full address decode
// A refused write (pslverr) leaves every register untouched

`timescale 1ns/100ps
`default_nettype none

module cordic_apb_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cordic_pkg::apb_req_t    apb_req,
  output cordic_pkg::apb_rsp_t    apb_rsp,
  input  logic                    busy,
  input  logic                    done,
  input  logic                    result_capture,
  input  cordic_pkg::cordic_res_t result,
  output logic                    start,
  output cordic_pkg::cordic_cmd_t cmd
);
  import cordic_pkg::*;

  logic        access;
  logic        addr_hit;
  logic        addr_ro;
  logic        start_bit;
  logic        err;
  logic        wr_ok;
  logic [31:0] rdata;

  fix_t        angle_q;
  fix_t        x_in_q;
  fix_t        y_in_q;
  fix_t        x_out_q;
  fix_t        y_out_q;
  opcode_e     opcode_q;

  // Access phase, completes in the same cycle
  assign access    = apb_req.psel & apb_req.penable;
  assign start_bit = (apb_req.paddr == REG_CTRL) & apb_req.pwdata[0];

  //////////////////////////////////////////////////
  // Address decode and read mux
  //////////////////////////////////////////////////
  always_comb begin
    addr_hit = 1'b1;
    addr_ro  = 1'b0;
    rdata    = '0;
    case (apb_req.paddr)
      REG_CTRL:   rdata = {30'd0, opcode_q, 1'b0};
      REG_STATUS: begin
        rdata   = {30'd0, done, busy};
        addr_ro = 1'b1;
      end
      REG_ANGLE:  rdata = 32'(angle_q);
      REG_X_IN:   rdata = 32'(x_in_q);
      REG_Y_IN:   rdata = 32'(y_in_q);
      REG_X_OUT:  begin
        rdata   = 32'(x_out_q);
        addr_ro = 1'b1;
      end
      REG_Y_OUT:  begin
        rdata   = 32'(y_out_q);
        addr_ro = 1'b1;
      end
      default:    addr_hit = 1'b0;
    endcase
  end

  // Start counts as busy while its pulse is still on the way to the FSM
  assign err   = !addr_hit | (apb_req.pwrite & (addr_ro | (start_bit & (busy | start))));
  assign wr_ok = access & apb_req.pwrite & !err;

  assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: access & err};

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start    <= 1'b0;
      opcode_q <= OP_SINCOS;
      angle_q  <= '0;
      x_in_q   <= '0;
      y_in_q   <= '0;
      x_out_q  <= '0;
      y_out_q  <= '0;
    end else begin
      // One-cycle pulse
      start <= wr_ok & start_bit;
      if (wr_ok) begin
        case (apb_req.paddr)
          REG_CTRL:  opcode_q <= opcode_e'(apb_req.pwdata[1]);
          REG_ANGLE: angle_q  <= fix_t'(apb_req.pwdata);
          REG_X_IN:  x_in_q   <= fix_t'(apb_req.pwdata);
          REG_Y_IN:  y_in_q   <= fix_t'(apb_req.pwdata);
          default:   ;
        endcase
      end
      // Result latched on the edge the FSM enters DONE
      if (result_capture) begin
        x_out_q <= result.x_out;
        y_out_q <= result.y_out;
      end
    end
  end

  assign cmd = '{opcode: opcode_q, angle: angle_q, x: x_in_q, y: y_in_q};

  // FSM must be idle or done whenever a start is handed over
  a_start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy);

  // Every accepted start makes the FSM busy on the next edge
  a_start_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start |=> busy);

endmodule

`default_nettype wire

/* logic/cordic_config.svh */
// Build-time sizing of the CORDIC engine
// Stage count is limited by the 16-entry arctangent table
// Fraction bits must leave room for pi plus the 1.647 gain growth

`ifndef CORDIC_CONFIG_SVH
`define CORDIC_CONFIG_SVH

// Width of angle, x and y words
`define CORDIC_DATA_WIDTH 16

// Number of micro-rotation stages, at most 16
`define CORDIC_STAGES 14

// Fixed-point fraction bits, 16/12 gives signed Q4.12
`define CORDIC_FRAC_BITS 12

// APB address width
`define CORDIC_APB_AW 8

`endif

/* logic/cordic_ctrl.sv */
// Command FSM, one command in flight at a time
// Expects start only while not busy

`timescale 1ns/100ps
`default_nettype none

module cordic_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  cordic_pkg::cordic_cmd_t cmd,
  output logic                    busy,
  output logic                    done,
  output logic                    issue_valid,
  output cordic_pkg::cordic_cmd_t issue_cmd,
  input  logic                    pipe_valid,
  input  cordic_pkg::cordic_vec_t pipe_vec,
  output logic                    result_capture,
  output cordic_pkg::cordic_res_t result
);
  import cordic_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_nxt;

  // Next-state logic
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      ST_IDLE, ST_DONE: if (start) state_nxt = ST_BUSY;
      ST_BUSY:          if (pipe_valid) state_nxt = ST_DONE;
      default:          state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ST_IDLE;
      issue_valid <= 1'b0;
    end else begin
      state_q     <= state_nxt;
      // Issue in the cycle after the start pulse
      issue_valid <= start;
    end
  end

  // Issued command held until the next start
  always_ff @(posedge clk) begin
    if (start) issue_cmd <= cmd;
  end

  assign busy = (state_q == ST_BUSY);
  assign done = (state_q == ST_DONE);

  // Pipe output goes straight to the result registers
  assign result_capture = busy & pipe_valid;
  assign result         = '{x_out: pipe_vec.x, y_out: pipe_vec.y};

  // No stray results from the datapath
  a_valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    pipe_valid |-> state_q == ST_BUSY);

endmodule

`default_nettype wire

/* logic/cordic_pkg.sv */
// Shared types, register map and fixed-point constants of the CORDIC engine
// Constants are rounded from real values at elaboration time

`default_nettype none
`include "cordic_config.svh"

package cordic_pkg;

  localparam int FRAC_BITS = `CORDIC_FRAC_BITS;

  // Signed fixed-point word for angles (radians) and vector components
  typedef logic signed [`CORDIC_DATA_WIDTH-1:0] fix_t;

  typedef enum logic {OP_SINCOS = 1'b0, OP_ROTATE = 1'b1} opcode_e;

  typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_DONE} ctrl_state_e;

  typedef struct packed {
    opcode_e opcode;
    fix_t    angle;
    fix_t    x;
    fix_t    y;
  } cordic_cmd_t;

  // z holds the angle still left to rotate
  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } cordic_vec_t;

  typedef struct packed {
    fix_t x_out;
    fix_t y_out;
  } cordic_res_t;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`CORDIC_APB_AW-1:0] paddr;
    logic [31:0]               pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Round a real value to the nearest fixed-point step
  function automatic fix_t to_fix(real r);
    return fix_t'($rtoi(r * real'(1 << FRAC_BITS) + ((r < 0.0) ? -0.5 : 0.5)));
  endfunction

  localparam fix_t PI_HALF         = to_fix(1.5707963268);
  localparam fix_t PI_FULL         = to_fix(3.1415926536);
  // 1/K for K = prod(sqrt(1 + 2^-2i))
  localparam fix_t CORDIC_INV_GAIN = to_fix(0.6072529350);

  // atan(2^-i), i = 0..15
  localparam fix_t ATAN_TABLE [16] = '{
    to_fix(0.7853981634), to_fix(0.4636476090), to_fix(0.2449786631), to_fix(0.1243549945),
    to_fix(0.0624188100), to_fix(0.0312398334), to_fix(0.0156237286), to_fix(0.0078123411),
    to_fix(0.0039062301), to_fix(0.0019531226), to_fix(0.0009765622), to_fix(0.0004882812),
    to_fix(0.0002441406), to_fix(0.0001220703), to_fix(0.0000610352), to_fix(0.0000305176)
  };

  // Register byte offsets
  localparam logic [`CORDIC_APB_AW-1:0] REG_CTRL   = 'h00;
  localparam logic [`CORDIC_APB_AW-1:0] REG_STATUS = 'h04;
  localparam logic [`CORDIC_APB_AW-1:0] REG_ANGLE  = 'h08;
  localparam logic [`CORDIC_APB_AW-1:0] REG_X_IN   = 'h0C;
  localparam logic [`CORDIC_APB_AW-1:0] REG_Y_IN   = 'h10;
  localparam logic [`CORDIC_APB_AW-1:0] REG_X_OUT  = 'h14;
  localparam logic [`CORDIC_APB_AW-1:0] REG_Y_OUT  = 'h18;

endpackage

`default_nettype wire

/* logic/cordic_quadrant_map.sv */
// Folds an angle in [-pi, pi] into [-pi/2, pi/2] with a 90 degree pre-rotation
// Angles outside [-pi, pi] give undefined results

`timescale 1ns/100ps
`default_nettype none

module cordic_quadrant_map (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  cordic_pkg::cordic_cmd_t in_cmd,
  output logic                    out_valid,
  output cordic_pkg::cordic_vec_t out_vec
);
  import cordic_pkg::*;

  fix_t        x_sel;
  fix_t        y_sel;
  cordic_vec_t vec_fold;

  always_comb begin
    // Sin/cos starts from the gain-compensated unit vector
    if (in_cmd.opcode == OP_SINCOS) begin
      x_sel = CORDIC_INV_GAIN;
      y_sel = '0;
    end else begin
      x_sel = in_cmd.x;
      y_sel = in_cmd.y;
    end
    // Sign of the angle is kept, only the magnitude is folded
    if (in_cmd.angle > PI_HALF) begin
      // +90 degrees: (x, y) -> (-y, x)
      vec_fold = '{x: -y_sel, y: x_sel, z: in_cmd.angle - PI_HALF};
    end else if (in_cmd.angle < -PI_HALF) begin
      // -90 degrees: (x, y) -> (y, -x)
      vec_fold = '{x: y_sel, y: -x_sel, z: in_cmd.angle + PI_HALF};
    end else begin
      vec_fold = '{x: x_sel, y: y_sel, z: in_cmd.angle};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) out_valid <= 1'b0;
    else        out_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (in_valid) out_vec <= vec_fold;
  end

  // Software must keep the angle within [-pi, pi]
  a_angle_range: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> (in_cmd.angle >= -PI_FULL) && (in_cmd.angle <= PI_FULL));

endmodule

`default_nettype wire

/* logic/cordic_rotation_pipe.sv */
// Rotation-mode CORDIC chain, one registered micro-rotation per stage
// Never stalls, latency is exactly CORDIC_STAGES cycles

`timescale 1ns/100ps
`default_nettype none
`include "cordic_config.svh"

module cordic_rotation_pipe (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  cordic_pkg::cordic_vec_t in_vec,
  output logic                    out_valid,
  output cordic_pkg::cordic_vec_t out_vec
);
  import cordic_pkg::*;

  localparam int STAGES = `CORDIC_STAGES;

  cordic_vec_t       vec_q [STAGES];
  logic [STAGES-1:0] vld_q;

  for (genvar i = 0; i < STAGES; i++) begin : g_stage
    cordic_vec_t cur;
    logic        cur_vld;
    fix_t        x_shr;
    fix_t        y_shr;
    logic        z_neg;

    // Stage 0 reads the folded vector
    if (i == 0) begin : g_first
      assign cur     = in_vec;
      assign cur_vld = in_valid;
    end else begin : g_next
      assign cur     = vec_q[i-1];
      assign cur_vld = vld_q[i-1];
    end

    // Arithmetic shift keeps the sign
    assign x_shr = cur.x >>> i;
    assign y_shr = cur.y >>> i;
    // Rotate toward z = 0
    assign z_neg = cur.z[$bits(fix_t)-1];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) vld_q[i] <= 1'b0;
      else        vld_q[i] <= cur_vld;
    end

    always_ff @(posedge clk) begin
      vec_q[i].x <= z_neg ? cur.x + y_shr         : cur.x - y_shr;
      vec_q[i].y <= z_neg ? cur.y - x_shr         : cur.y + x_shr;
      vec_q[i].z <= z_neg ? cur.z + ATAN_TABLE[i] : cur.z - ATAN_TABLE[i];
    end
  end

  assign out_valid = vld_q[STAGES-1];
  assign out_vec   = vec_q[STAGES-1];

  a_stage_limit: assert property (@(posedge clk) STAGES <= $size(ATAN_TABLE));

endmodule

`default_nettype wire

/* logic/cordic_top.sv */
// APB-programmable CORDIC rotation engine
// Done shows in STATUS CORDIC_STAGES + 3 cycles after the start write

`timescale 1ns/100ps
`default_nettype none

module cordic_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cordic_pkg::apb_req_t apb_req,
  output cordic_pkg::apb_rsp_t apb_rsp
);
  import cordic_pkg::*;

  // Register file <-> FSM
  logic        start;
  logic        busy;
  logic        done;
  logic        result_capture;
  cordic_cmd_t cmd;
  cordic_res_t result;

  // FSM -> datapath -> FSM
  logic        issue_valid;
  cordic_cmd_t issue_cmd;
  logic        fold_valid;
  cordic_vec_t fold_vec;
  logic        pipe_valid;
  cordic_vec_t pipe_vec;

  cordic_apb_regs u_regs (
    .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .busy(busy), .done(done), .result_capture(result_capture), .result(result),
    .start(start), .cmd(cmd)
  );

  cordic_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .cmd(cmd), .busy(busy), .done(done),
    .issue_valid(issue_valid), .issue_cmd(issue_cmd), .pipe_valid(pipe_valid),
    .pipe_vec(pipe_vec), .result_capture(result_capture), .result(result)
  );

  cordic_quadrant_map u_fold (
    .clk(clk), .rst_n(rst_n), .in_valid(issue_valid), .in_cmd(issue_cmd),
    .out_valid(fold_valid), .out_vec(fold_vec)
  );

  cordic_rotation_pipe u_pipe (
    .clk(clk), .rst_n(rst_n), .in_valid(fold_valid), .in_vec(fold_vec),
    .out_valid(pipe_valid), .out_vec(pipe_vec)
  );

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/cordic_pkg.sv
logic/cordic_apb_regs.sv
logic/cordic_ctrl.sv
logic/cordic_quadrant_map.sv
logic/cordic_rotation_pipe.sv
logic/cordic_top.sv
tests/cordic_tb.sv

/* tests/cordic_tb.sv */
// Self-checking testbench for the APB CORDIC engine, random stimulus from seed 32'h1df7
// Expected values come from a real sin/cos model, tolerance 8 LSB (sincos), 12 LSB (rotate)

`timescale 1ns/100ps
`default_nettype none
`include "cordic_config.svh"

module cordic_tb;
  import cordic_pkg::*;

  localparam real SCALE      = real'(1 << `CORDIC_FRAC_BITS);
  localparam real GAIN       = 1.6468;
  // pi, pi/2 and 1/sqrt(2) in LSB units
  localparam int  ANGLE_MAX  = int'(3.1415926536 * SCALE);
  localparam int  HALF_MAX   = int'(1.5707963268 * SCALE);
  localparam int  VEC_MAX    = int'(0.7071 * SCALE);
  localparam int  CORNERS[5] = '{ANGLE_MAX, -ANGLE_MAX, HALF_MAX, -HALF_MAX, 0};
  // Reset and register checks, 40 sincos, 20 rotate, one refused restart; margin of 2
  localparam int  NUM_TESTS  = 64;
  localparam int  TIMEOUT_NS = 2 * NUM_TESTS * (`CORDIC_STAGES + 20) * 20;

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  integer   seed = 32'h1df7;

  cordic_top dut (.clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic raise_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  a_pready: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && apb_req.penable |-> apb_rsp.pready)
    else raise_error("pready low in access phase");

  // Error response only in the access phase
  a_err_phase: assert property (@(posedge clk) disable iff (!rst_n)
    apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
    else raise_error("pslverr outside access phase");

  function automatic bit near(input fix_t got, input real want, input int tol);
    real diff;
    diff = real'(got) - want;
    return (diff <= real'(tol)) && (diff >= -real'(tol));
  endfunction

  //////////////////////////////////////////////////
  // APB transfers
  //////////////////////////////////////////////////
  // Setup, access, sampled mid access phase, then idle
  task automatic apb_xfer(input logic write, input logic [`CORDIC_APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic write_reg(input logic [`CORDIC_APB_AW-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    assert (err == exp_err)
      else raise_error($sformatf("write to %0h: pslverr %0b, expected %0b", addr, err, exp_err));
  endtask

  task automatic read_reg(input logic [`CORDIC_APB_AW-1:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'h0, data, err);
    assert (!err) else raise_error($sformatf("read of %0h got pslverr", addr));
  endtask

  // Busy must show on the first poll after a start
  task automatic poll_done();
    logic [31:0] st;
    read_reg(REG_STATUS, st);
    assert (st[1:0] == 2'b01)
      else raise_error($sformatf("status %0h after start, busy only expected", st));
    while (!st[1]) read_reg(REG_STATUS, st);
    assert (!st[0]) else raise_error("busy and done both set");
  endtask

  //////////////////////////////////////////////////
  // Reference model and command runs
  //////////////////////////////////////////////////
  task automatic check_result(input opcode_e op, input fix_t ang, input fix_t x,
                              input fix_t y, input fix_t xo, input fix_t yo);
    real a;
    real ex;
    real ey;
    int  tol;
    a = real'(ang) / SCALE;
    if (op == OP_SINCOS) begin
      ex  = $cos(a) * SCALE;
      ey  = $sin(a) * SCALE;
      tol = 8;
    end else begin
      ex  = GAIN * (real'(x) * $cos(a) - real'(y) * $sin(a));
      ey  = GAIN * (real'(x) * $sin(a) + real'(y) * $cos(a));
      tol = 12;
    end
    // Signed tolerance window also catches a lost sign on negative angles
    assert (near(xo, ex, tol) && near(yo, ey, tol))
      else raise_error($sformatf(
        "op %s angle %0d vec (%0d, %0d): got (%0d, %0d) exp (%0.1f, %0.1f)",
        op.name(), ang, x, y, xo, yo, ex, ey));
  endtask

  task automatic run_cmd(input opcode_e op, input fix_t ang, input fix_t x, input fix_t y,
                         input bit restart);
    logic [31:0] rd;
    fix_t        xo;
    fix_t        yo;
    write_reg(REG_ANGLE, 32'(ang), 1'b0);
    write_reg(REG_X_IN, 32'(x), 1'b0);
    write_reg(REG_Y_IN, 32'(y), 1'b0);
    write_reg(REG_CTRL, {30'd0, op, 1'b1}, 1'b0);
    // Second start reaches the slave while the first command is in the pipe
    if (restart) write_reg(REG_CTRL, {30'd0, ~op, 1'b1}, 1'b1);
    poll_done();
    read_reg(REG_X_OUT, rd);
    xo = fix_t'(rd[15:0]);
    read_reg(REG_Y_OUT, rd);
    yo = fix_t'(rd[15:0]);
    check_result(op, ang, x, y, xo, yo);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic        err;
    fix_t        ang;
    rst_n   = 1'b0;
    apb_req = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    read_reg(REG_STATUS, rd);
    assert (rd == 32'h0) else raise_error($sformatf("status %0h after reset", rd));
    read_reg(REG_X_OUT, rd);
    assert (rd == 32'h0) else raise_error($sformatf("x_out %0h after reset", rd));
    read_reg(REG_Y_OUT, rd);
    assert (rd == 32'h0) else raise_error($sformatf("y_out %0h after reset", rd));
    // Unmapped offset and read-only targets
    write_reg(8'h1C, 32'h5, 1'b1);
    apb_xfer(1'b0, 8'h1C, 32'h0, rd, err);
    assert (err) else raise_error("read of unmapped offset 1c got no pslverr");
    write_reg(REG_X_OUT, 32'h123, 1'b1);
    write_reg(REG_ANGLE, 32'(fix_t'(-1234)), 1'b0);
    write_reg(REG_X_IN, 32'h0777, 1'b0);
    write_reg(REG_Y_IN, 32'(fix_t'(-42)), 1'b0);
    read_reg(REG_ANGLE, rd);
    assert (fix_t'(rd[15:0]) == -1234) else raise_error($sformatf("angle readback %0h", rd));
    read_reg(REG_X_IN, rd);
    assert (rd[15:0] == 16'h0777) else raise_error($sformatf("x_in readback %0h", rd));
    read_reg(REG_Y_IN, rd);
    assert (fix_t'(rd[15:0]) == -42) else raise_error($sformatf("y_in readback %0h", rd));
    // Corner angles first, then random ones
    for (int i = 0; i < 40; i++) begin
      if (i < 5) ang = fix_t'(CORNERS[i]);
      else       ang = fix_t'($random(seed) % (ANGLE_MAX + 1));
      run_cmd(OP_SINCOS, ang, '0, '0, 1'b0);
    end
    for (int i = 0; i < 20; i++) begin
      run_cmd(OP_ROTATE, fix_t'($random(seed) % (ANGLE_MAX + 1)),
              fix_t'($random(seed) % (VEC_MAX + 1)), fix_t'($random(seed) % (VEC_MAX + 1)),
              1'b0);
    end
    run_cmd(OP_SINCOS, fix_t'(-2000), '0, '0, 1'b1);
    $display("=== PASS ===");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("=== FAIL ===");
    $fatal(1);
  end

endmodule

`default_nettype wire
